/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dma_desc
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
hw/dma_pkg.sv
hw/desc_if.sv
hw/desc_fetch.sv
hw/desc_queue.sv
hw/job_dispatch.sv
hw/dma_desc_top.sv
sim/wb_mem_model.sv
sim/tb_dma_desc.sv

/* hw/desc_fetch.sv */
// Wishbone classic master that reads descriptor chains and pushes each descriptor downstream
`timescale 1ns/1ps

module desc_fetch (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        start_i,
   input  logic [31:3] ndar_i,
   output logic        wb_cyc_o,
   output logic        wb_stb_o,
   output logic        wb_we_o,
   output logic [31:0] wb_adr_o,
   output logic [3:0]  wb_sel_o,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack_i,
   input  logic        wb_err_i,
   input  logic        wb_rty_i,
   output logic        err_o,
   output logic        fetch_busy_o,
   desc_if.producer    desc_o
);
   import dma_pkg::*;

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_READ = 2'd1;
   localparam logic [1:0] S_PUSH = 2'd2;

   logic [1:0]             state;
   logic [DESC_ADDR_W-1:0] base_q;   // address of descriptor in flight
   logic [DESC_ADDR_W-1:0] next_q;   // captured chain pointer
   logic [31:0]            ctl_q;
   logic                   widx_q;   // word within descriptor
   logic                   cyc_q;
   logic                   stb_q;
   logic                   valid_q;
   logic                   err_q;
   logic                   take;
   logic                   last_word;
   logic                   pushed;
   logic                   follow;

   // retry counts as no ack, same word is requested again
   assign take      = stb_q & wb_ack_i & ~wb_err_i & ~wb_rty_i;
   assign last_word = widx_q == 1'(DESC_WORDS - 1);
   assign pushed    = (state == S_PUSH) & desc_o.ready;
   assign follow    = pushed & ctl_q[CHAIN_BIT];

   assign wb_cyc_o     = cyc_q;
   assign wb_stb_o     = stb_q;
   assign wb_we_o      = 1'b0;                       // read only master
   assign wb_sel_o     = 4'hf;
   assign wb_adr_o     = {base_q, widx_q, 2'b00};    // base, then base+4
   assign err_o        = err_q;
   assign fetch_busy_o = state != S_IDLE;

   assign desc_o.valid = valid_q;
   assign desc_o.daddr = base_q;
   assign desc_o.ctl   = ctl_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state   <= S_IDLE;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         valid_q <= 1'b0;
         err_q   <= 1'b0;
         widx_q  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start_i) begin
                  err_q  <= 1'b0;            // new run clears the sticky error
                  cyc_q  <= 1'b1;
                  stb_q  <= 1'b1;
                  widx_q <= 1'b0;
                  state  <= S_READ;
               end
            end
            S_READ: begin
               if (stb_q && wb_err_i) begin
                  cyc_q <= 1'b0;             // drop this descriptor
                  stb_q <= 1'b0;
                  err_q <= 1'b1;
                  state <= S_IDLE;
               end else if (take) begin
                  if (last_word) begin
                     cyc_q   <= 1'b0;
                     stb_q   <= 1'b0;
                     valid_q <= 1'b1;
                     state   <= S_PUSH;
                  end else begin
                     widx_q <= widx_q + 1'b1;
                  end
               end
            end
            S_PUSH: begin
               if (desc_o.ready) begin
                  valid_q <= 1'b0;
                  if (ctl_q[CHAIN_BIT]) begin
                     cyc_q  <= 1'b1;         // next fetch right away
                     stb_q  <= 1'b1;
                     widx_q <= 1'b0;
                     state  <= S_READ;
                  end else begin
                     state <= S_IDLE;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // descriptor payload
   always_ff @(posedge wb_clk_i) begin
      if (state == S_IDLE && start_i) begin
         base_q <= ndar_i;
      end else if (follow) begin
         base_q <= next_q;
      end
      if (state == S_READ && take) begin
         if (last_word) begin
            ctl_q <= wb_dat_i;
         end else begin
            next_q <= wb_dat_i[31:3];
         end
      end
   end

   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_stb_o |-> wb_cyc_o)
      else $error("wb_stb_o high outside a bus cycle");

endmodule

/* hw/desc_if.sv */
// valid/ready descriptor channel between the fetcher, the queue and the dispatcher
`timescale 1ns/1ps

interface desc_if;
   import dma_pkg::*;

   logic                   valid;
   logic                   ready;
   logic [DESC_ADDR_W-1:0] daddr;   // descriptor's own address, bits 31..3
   logic [31:0]            ctl;     // raw control word

   modport producer (
      output valid,
      output daddr,
      output ctl,
      input  ready
   );

   modport consumer (
      input  valid,
      input  daddr,
      input  ctl,
      output ready
   );

endinterface

/* hw/desc_queue.sv */
// circular FIFO of fetched descriptors between the fetcher and the dispatcher
`timescale 1ns/1ps

module desc_queue #(
   parameter int QDEPTH = 4
) (
   input  logic     wb_clk_i,
   input  logic     wb_rst_i,
   desc_if.consumer in_i,
   desc_if.producer out_o
);
   import dma_pkg::*;

   localparam int AW = $clog2(QDEPTH);
   localparam int CW = $clog2(QDEPTH + 1);

   logic [DESC_ADDR_W-1:0] addr_mem [QDEPTH];
   logic [31:0]            ctl_mem  [QDEPTH];
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [CW-1:0]          count;
   logic                   full;
   logic                   empty;
   logic                   push;
   logic                   pop;

   assign full  = count == CW'(QDEPTH);
   assign empty = count == '0;

   // a full queue still takes an item when one leaves on the same edge
   assign in_i.ready  = ~full | out_o.ready;
   assign push        = in_i.valid & in_i.ready;
   assign out_o.valid = ~empty;
   assign pop         = out_o.valid & out_o.ready;
   assign out_o.daddr = addr_mem[rd_ptr];
   assign out_o.ctl   = ctl_mem[rd_ptr];

   always_ff @(posedge wb_clk_i) begin
      if (push) begin
         addr_mem[wr_ptr] <= in_i.daddr;
         ctl_mem[wr_ptr]  <= in_i.ctl;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;         // wraps, depth is a power of two
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      count <= CW'(QDEPTH))
      else $error("descriptor queue count above depth");

endmodule

/* hw/dma_desc_top.sv */
// top level of the descriptor DMA front end, wiring fetcher, queue and dispatcher
`timescale 1ns/1ps

module dma_desc_top #(
   parameter int QDEPTH = 4
) (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   input  logic                      start_i,
   input  logic [31:3]               ndar_i,
   output logic                      wb_cyc_o,
   output logic                      wb_stb_o,
   output logic                      wb_we_o,
   output logic [31:0]               wb_adr_o,
   output logic [3:0]                wb_sel_o,
   input  logic [31:0]               wb_dat_i,
   input  logic                      wb_ack_i,
   input  logic                      wb_err_i,
   input  logic                      wb_rty_i,
   output logic                      job_valid_o,
   output logic [dma_pkg::LEN_W-1:0] job_len_o,
   output logic [dma_pkg::TAG_W-1:0] job_tag_o,
   input  logic                      job_done_i,
   input  logic                      int_clr_i,
   output logic                      int_o,
   output logic                      err_o,
   output logic                      busy_o,
   output logic [31:0]               cur_desc_o
);

   logic fetch_busy;

   desc_if fq_if ();   // fetcher to queue
   desc_if qd_if ();   // queue to dispatcher

   desc_fetch u_fetch (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .start_i      (start_i),
      .ndar_i       (ndar_i),
      .wb_cyc_o     (wb_cyc_o),
      .wb_stb_o     (wb_stb_o),
      .wb_we_o      (wb_we_o),
      .wb_adr_o     (wb_adr_o),
      .wb_sel_o     (wb_sel_o),
      .wb_dat_i     (wb_dat_i),
      .wb_ack_i     (wb_ack_i),
      .wb_err_i     (wb_err_i),
      .wb_rty_i     (wb_rty_i),
      .err_o        (err_o),
      .fetch_busy_o (fetch_busy),
      .desc_o       (fq_if.producer)
   );

   desc_queue #(
      .QDEPTH (QDEPTH)
   ) u_queue (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .in_i     (fq_if.consumer),
      .out_o    (qd_if.producer)
   );

   job_dispatch u_dispatch (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .desc_i       (qd_if.consumer),
      .fetch_busy_i (fetch_busy),
      .job_valid_o  (job_valid_o),
      .job_len_o    (job_len_o),
      .job_tag_o    (job_tag_o),
      .job_done_i   (job_done_i),
      .int_clr_i    (int_clr_i),
      .int_o        (int_o),
      .cur_desc_o   (cur_desc_o),
      .busy_o       (busy_o)
   );

endmodule

/* hw/dma_pkg.sv */
// descriptor layout constants, imported by the DMA front end blocks and the testbench
package dma_pkg;

   // descriptor addresses are 8-byte aligned, bits 31..3 only
   localparam int DESC_ADDR_W = 29;

   // words per descriptor, word 0 next pointer, word 1 control
   localparam int DESC_WORDS  = 2;

   // control word fields
   localparam int LEN_W       = 14;     // job length in bits 13..0
   localparam int CHAIN_BIT   = 14;     // follow next pointer
   localparam int IRQ_BIT     = 15;     // raise interrupt on completion
   localparam int TAG_LSB     = 16;     // job tag low bit
   localparam int TAG_W       = 8;      // tag in bits 23..16

endpackage

/* hw/job_dispatch.sv */
// hands queued descriptors to the transfer channel and keeps completion and interrupt state
`timescale 1ns/1ps

module job_dispatch (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   desc_if.consumer                  desc_i,
   input  logic                      fetch_busy_i,
   output logic                      job_valid_o,
   output logic [dma_pkg::LEN_W-1:0] job_len_o,
   output logic [dma_pkg::TAG_W-1:0] job_tag_o,
   input  logic                      job_done_i,
   input  logic                      int_clr_i,
   output logic                      int_o,
   output logic [31:0]               cur_desc_o,
   output logic                      busy_o
);
   import dma_pkg::*;

   logic                   job_open;
   logic [LEN_W-1:0]       len_q;
   logic [TAG_W-1:0]       tag_q;
   logic                   irq_q;     // job asks for an interrupt
   logic [DESC_ADDR_W-1:0] daddr_q;
   logic                   take;
   logic                   finish;
   logic                   int_set;

   assign desc_i.ready = ~job_open;   // one job at a time
   assign take         = desc_i.valid & desc_i.ready;
   assign finish       = job_open & job_done_i;
   assign int_set      = finish & irq_q;

   assign job_valid_o = job_open;
   assign job_len_o   = len_q;
   assign job_tag_o   = tag_q;
   assign busy_o      = fetch_busy_i | desc_i.valid | job_open;

   always_ff @(posedge wb_clk_i) begin
      if (take) begin
         len_q   <= desc_i.ctl[LEN_W-1:0];
         tag_q   <= desc_i.ctl[TAG_LSB +: TAG_W];
         irq_q   <= desc_i.ctl[IRQ_BIT];
         daddr_q <= desc_i.daddr;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         job_open   <= 1'b0;
         int_o      <= 1'b0;
         cur_desc_o <= 32'h0;
      end else begin
         if (take) begin
            job_open <= 1'b1;
         end else if (finish) begin
            job_open   <= 1'b0;
            cur_desc_o <= {daddr_q, 3'b000};   // byte address of finished descriptor
         end
         if (int_set) begin
            int_o <= 1'b1;                     // set beats clear
         end else if (int_clr_i) begin
            int_o <= 1'b0;
         end
      end
   end

   a_job_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      job_valid_o && !job_done_i |=> $stable({job_len_o, job_tag_o}))
      else $error("job fields changed while the job was open");

endmodule

/* sim/tb_dma_desc.sv */
// testbench for the descriptor DMA front end, runs a table of chains against a memory model
`timescale 1ns/1ps

module tb_dma_desc;
   import dma_pkg::*;

   localparam int          NROWS  = 6;
   localparam int          NJOBS  = 23;
   localparam int          QDEPTH = 4;
   localparam logic [31:0] SEED   = 32'h78c7_9668;
   localparam logic [31:0] STRIDE = 32'h40;   // gap between descriptors of one chain

   typedef struct packed {
      logic [31:0] start;      // first descriptor byte address
      logic [3:0]  ndesc;
      logic [4:0]  first;      // first pair in the job table
      logic [31:0] err_adr;    // 0 means no error
      logic [7:0]  irq_mask;   // bit i is descriptor i
      logic        clear_int;
      logic        slow;       // long channel delays
      logic [3:0]  exp_jobs;
      logic [3:0]  exp_ints;
      logic [31:0] exp_cur;
      logic        exp_err;
   } row_t;

   // start n first err-addr irq clr slow jobs ints cur err
   localparam row_t ROWS [NROWS] = '{
      '{32'h080, 4'd1, 5'd0, 32'h000, 8'h01, 1'b1, 1'b0, 4'd1, 4'd1, 32'h080, 1'b0},
      '{32'h300, 4'd5, 5'd1, 32'h000, 8'h15, 1'b1, 1'b0, 4'd5, 4'd3, 32'h400, 1'b0},
      '{32'h600, 4'd5, 5'd6, 32'h000, 8'h1a, 1'b0, 1'b0, 4'd5, 4'd1, 32'h700, 1'b0},
      '{32'h900, 4'd6, 5'd11, 32'h000, 8'h21, 1'b1, 1'b1, 4'd6, 4'd2, 32'ha40, 1'b0},
      '{32'hc00, 4'd5, 5'd17, 32'hc80, 8'h03, 1'b1, 1'b0, 4'd2, 4'd2, 32'hc40, 1'b1},
      '{32'h0c0, 4'd1, 5'd22, 32'h000, 8'h00, 1'b1, 1'b0, 4'd1, 4'd0, 32'h0c0, 1'b0}
   };

   // length and tag of every descriptor, in chain order
   localparam logic [LEN_W+TAG_W-1:0] JOBS [NJOBS] = '{
      {14'd64, 8'h11},
      {14'd128, 8'h21}, {14'd4, 8'h22}, {14'd1000, 8'h23}, {14'd16383, 8'h24}, {14'd1, 8'h25},
      {14'd32, 8'h31}, {14'd33, 8'h32}, {14'd34, 8'h33}, {14'd35, 8'h34}, {14'd36, 8'h35},
      {14'd500, 8'h41}, {14'd501, 8'h42}, {14'd502, 8'h43}, {14'd503, 8'h44},
      {14'd504, 8'h45}, {14'd505, 8'h46},
      {14'd7, 8'h51}, {14'd8, 8'h52}, {14'd9, 8'h53}, {14'd10, 8'h54}, {14'd11, 8'h55},
      {14'd2048, 8'hf0}
   };

   logic               wb_clk_i;
   logic               wb_rst_i;
   logic               start_i;
   logic [31:3]        ndar_i;
   logic               wb_cyc_o;
   logic               wb_stb_o;
   logic               wb_we_o;
   logic [31:0]        wb_adr_o;
   logic [3:0]         wb_sel_o;
   logic [31:0]        wb_dat_i;
   logic               wb_ack_i;
   logic               wb_err_i;
   logic               wb_rty_i;
   logic               job_valid_o;
   logic [LEN_W-1:0]   job_len_o;
   logic [TAG_W-1:0]   job_tag_o;
   logic               job_done_i;
   logic               int_clr_i;
   logic               int_o;
   logic               err_o;
   logic               busy_o;
   logic [31:0]        cur_desc_o;
   logic [31:0]        err_adr;
   logic [LEN_W-1:0]   got_len [$];   // jobs seen by the channel model
   logic [TAG_W-1:0]   got_tag [$];
   logic               clear_mode;    // pulse int_clr_i after each interrupt
   logic               slow_mode;
   logic               int_seen;
   int                 int_edges;
   int                 n_checks;
   int                 n_errors;

   dma_desc_top #(
      .QDEPTH (QDEPTH)
   ) uut (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .start_i     (start_i),
      .ndar_i      (ndar_i),
      .wb_cyc_o    (wb_cyc_o),
      .wb_stb_o    (wb_stb_o),
      .wb_we_o     (wb_we_o),
      .wb_adr_o    (wb_adr_o),
      .wb_sel_o    (wb_sel_o),
      .wb_dat_i    (wb_dat_i),
      .wb_ack_i    (wb_ack_i),
      .wb_err_i    (wb_err_i),
      .wb_rty_i    (wb_rty_i),
      .job_valid_o (job_valid_o),
      .job_len_o   (job_len_o),
      .job_tag_o   (job_tag_o),
      .job_done_i  (job_done_i),
      .int_clr_i   (int_clr_i),
      .int_o       (int_o),
      .err_o       (err_o),
      .busy_o      (busy_o),
      .cur_desc_o  (cur_desc_o)
   );

   wb_mem_model #(
      .WORDS (1024)
   ) u_mem (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .wb_cyc_i  (wb_cyc_o),
      .wb_stb_i  (wb_stb_o),
      .wb_we_i   (wb_we_o),
      .wb_adr_i  (wb_adr_o),
      .wb_sel_i  (wb_sel_o),
      .wb_dat_o  (wb_dat_i),
      .wb_ack_o  (wb_ack_i),
      .wb_err_o  (wb_err_i),
      .wb_rty_o  (wb_rty_i),
      .err_adr_i (err_adr)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #20 wb_clk_i = ~wb_clk_i;
   end

   task automatic check_job(input string what, input logic [LEN_W-1:0] len,
                            input logic [TAG_W-1:0] tag, input logic [LEN_W-1:0] exp_len,
                            input logic [TAG_W-1:0] exp_tag);
      n_checks++;
      if (len !== exp_len || tag !== exp_tag) begin
         n_errors++;
         $display("mismatch at %0t: %s len %0d tag %0h, expected len %0d tag %0h",
                  $time, what, len, tag, exp_len, exp_tag);
      end
   endtask

   task automatic check_addr(input string what, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         n_errors++;
         $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // writes one chain into the memory model, next pointer then control word
   task automatic load_row(input int r);
      logic [31:0]            adr;
      logic [31:0]            ctl;
      logic [LEN_W+TAG_W-1:0] pair;
      adr = ROWS[r].start;
      for (int i = 0; i < int'(ROWS[r].ndesc); i++) begin
         pair                  = JOBS[int'(ROWS[r].first) + i];
         ctl                   = 32'h0;
         ctl[LEN_W-1:0]        = pair[TAG_W +: LEN_W];
         ctl[TAG_LSB +: TAG_W] = pair[TAG_W-1:0];
         ctl[IRQ_BIT]          = ROWS[r].irq_mask[i];
         ctl[CHAIN_BIT]        = i < int'(ROWS[r].ndesc) - 1;   // last one ends the chain
         u_mem.mem[{adr[11:3], 1'b0}] = ctl[CHAIN_BIT] ? adr + STRIDE : 32'h0;
         u_mem.mem[{adr[11:3], 1'b1}] = ctl;
         adr = adr + STRIDE;
      end
      err_adr = ROWS[r].err_adr;
   endtask

   task automatic run_row(input int r);
      int                     ints_before;
      int                     n;
      logic [LEN_W+TAG_W-1:0] pair;
      @(negedge wb_clk_i);
      load_row(r);
      got_len.delete();
      got_tag.delete();
      clear_mode  = ROWS[r].clear_int;
      slow_mode   = ROWS[r].slow;
      ints_before = int_edges;
      @(posedge wb_clk_i);
      start_i <= 1'b1;
      ndar_i  <= ROWS[r].start[31:3];
      @(posedge wb_clk_i);
      start_i <= 1'b0;
      @(negedge wb_clk_i);
      check_flag("err_o after start", err_o, 1'b0);
      check_flag("busy_o after start", busy_o, 1'b1);
      while (busy_o) begin
         @(negedge wb_clk_i);
      end
      repeat (4) @(negedge wb_clk_i);   // last interrupt edge reaches the monitor
      check_count("job count", got_len.size(), int'(ROWS[r].exp_jobs));
      n = got_len.size() < int'(ROWS[r].exp_jobs) ? got_len.size() : int'(ROWS[r].exp_jobs);
      for (int i = 0; i < n; i++) begin
         pair = JOBS[int'(ROWS[r].first) + i];
         check_job("job", got_len[i], got_tag[i], pair[TAG_W +: LEN_W], pair[TAG_W-1:0]);
      end
      check_count("interrupt edges", int_edges - ints_before, int'(ROWS[r].exp_ints));
      check_flag("int_o level", int_o, ~ROWS[r].clear_int & (ROWS[r].exp_ints != 4'd0));
      check_addr("cur_desc_o", cur_desc_o, ROWS[r].exp_cur);
      check_flag("err_o", err_o, ROWS[r].exp_err);
      clear_mode = 1'b1;                // drop a held interrupt before the next chain
      while (int_o) begin
         @(negedge wb_clk_i);
      end
   endtask

   // transfer channel, takes each job once and answers after a random delay
   initial begin
      int delay;
      job_done_i = 1'b0;
      forever begin
         @(posedge wb_clk_i);
         if (job_valid_o && !job_done_i) begin
            got_len.push_back(job_len_o);
            got_tag.push_back(job_tag_o);
            delay = slow_mode ? int'($urandom_range(1, 40)) : int'($urandom_range(1, 6));
            repeat (delay - 1) @(posedge wb_clk_i);
            job_done_i <= 1'b1;
            @(posedge wb_clk_i);
            job_done_i <= 1'b0;
         end
      end
   end

   // interrupt monitor, counts rising edges of int_o
   initial begin
      int_clr_i = 1'b0;
      int_seen  = 1'b0;
      int_edges = 0;
      forever begin
         @(posedge wb_clk_i);
         int_clr_i <= 1'b0;
         if (int_o && !int_seen) begin
            int_edges = int_edges + 1;
         end
         if (int_o && clear_mode) begin
            int_clr_i <= 1'b1;
         end
         int_seen = int_o;
      end
   end

   // bus monitor, the fetcher only reads whole words
   initial begin
      forever begin
         @(negedge wb_clk_i);
         if (wb_stb_o) begin
            check_flag("wb_we_o during a fetch", wb_we_o, 1'b0);
            check_flag("wb_sel_o selects all lanes", wb_sel_o == 4'hf, 1'b1);
         end
      end
   end

   initial begin
      repeat (NROWS * 2000) @(posedge wb_clk_i);
      $display("watchdog expired after %0d cycles, the chains did not finish", NROWS * 2000);
      $display("%0d checks, %0d errors", n_checks, n_errors);
      $display("Test failed");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      wb_rst_i   = 1'b1;
      start_i    = 1'b0;
      ndar_i     = '0;
      err_adr    = 32'h0;
      clear_mode = 1'b1;
      slow_mode  = 1'b0;
      n_checks   = 0;
      n_errors   = 0;
      repeat (16) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      @(negedge wb_clk_i);
      check_flag("wb_cyc_o after reset", wb_cyc_o, 1'b0);
      check_flag("wb_stb_o after reset", wb_stb_o, 1'b0);
      check_flag("job_valid_o after reset", job_valid_o, 1'b0);
      check_flag("int_o after reset", int_o, 1'b0);
      check_flag("err_o after reset", err_o, 1'b0);
      check_flag("busy_o after reset", busy_o, 1'b0);
      check_addr("cur_desc_o after reset", cur_desc_o, 32'h0);
      for (int r = 0; r < NROWS; r++) begin
         run_row(r);
      end
      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* sim/wb_mem_model.sv */
// Wishbone classic slave memory for the testbench, with random wait states and one error address
`timescale 1ns/1ps

module wb_mem_model #(
   parameter int WORDS = 1024
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [31:0] wb_adr_i,
   input  logic [3:0]  wb_sel_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic        wb_rty_o,
   input  logic [31:0] err_adr_i
);

   localparam int AW = $clog2(WORDS);

   logic [31:0]   mem [WORDS];   // loaded by the testbench
   logic [AW-1:0] idx;
   logic          busy;          // request seen, counting wait states
   logic [1:0]    wait_cnt;
   logic          req;
   logic          err_hit;
   logic [31:0]   lane_mask;     // byte lanes selected by the master

   assign idx       = wb_adr_i[AW+1:2];
   assign req       = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
   assign err_hit   = (err_adr_i != 32'h0) && (wb_adr_i[31:2] == err_adr_i[31:2]);
   assign lane_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};
   assign wb_rty_o  = 1'b0;      // never retries

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hbad0_0000 | (32'(i) << 2);   // byte address shows in stale reads
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         busy     <= 1'b0;
         wait_cnt <= 2'd0;
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
         wb_dat_o <= 32'h0;
      end else begin
         wb_ack_o <= 1'b0;                       // single cycle responses
         wb_err_o <= 1'b0;
         if (!(wb_cyc_i && wb_stb_i)) begin
            busy <= 1'b0;
         end else if (req) begin
            if (!busy) begin
               busy     <= 1'b1;
               wait_cnt <= 2'($urandom_range(0, 3));
            end else if (wait_cnt != 2'd0) begin
               wait_cnt <= wait_cnt - 2'd1;
            end else begin
               busy <= 1'b0;
               if (err_hit || wb_we_i) begin
                  wb_err_o <= 1'b1;              // read only, writes fail
               end else begin
                  wb_ack_o <= 1'b1;
                  wb_dat_o <= mem[idx] & lane_mask;
               end
            end
         end
      end
   end

endmodule
